// ==== dcache_settings.svh ====
/*
 dcache geometry
 widths of address, data, tag, index and byte mask for the
 two-way data cache, plus the number of sets per way
*/
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// core and memory word
`define DC_ADDR_W 64
`define DC_DATA_W 64

// tag is addr[63:9], index is addr[8:3]
`define DC_TAG_W  55
`define DC_IDX_W  6

// one enable per data byte
`define DC_MASK_W 8

// entries in each way
`define DC_SETS   64

`endif

// ==== dcache_pkg.sv ====
/*
 dcache types
 address view shared by the ways and the controller, and the
 controller state encoding
*/
`include "dcache_settings.svh"

package dcache_pkg;

    typedef struct packed {
        logic [`DC_TAG_W-1:0]                       tag;
        logic [`DC_IDX_W-1:0]                       index;
        logic [`DC_ADDR_W-`DC_TAG_W-`DC_IDX_W-1:0]  offset;
    } dcache_addr_fields_t;

    // same 64 bits, seen raw or split into fields
    typedef union packed {
        logic [`DC_ADDR_W-1:0] word;
        dcache_addr_fields_t   f;
    } dcache_addr_t;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOOKUP = 3'd1,
        WBACK  = 3'd2,
        FILL   = 3'd3,
        DONE   = 3'd4
    } dc_state_t;

endpackage

// ==== dcache_way.sv ====
/*
 dcache way
 one way of the data cache: tag, valid, dirty and data arrays
 indexed by set, with its own tag compare and byte-masked writes
*/
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_way (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`DC_IDX_W-1:0]  index_i,
    input  logic [`DC_TAG_W-1:0]  tag_i,
    input  logic                  wr_en_i,
    input  logic [`DC_MASK_W-1:0] wmask_i,
    input  logic [`DC_DATA_W-1:0] wdata_i,
    input  logic                  fill_i,
    input  logic                  set_dirty_i,
    output logic                  hit_o,
    output logic                  valid_o,
    output logic                  dirty_o,
    output logic [`DC_TAG_W-1:0]  tag_o,
    output logic [`DC_DATA_W-1:0] rdata_o
);

    logic [`DC_TAG_W-1:0]  tag_mem  [`DC_SETS];
    logic [`DC_DATA_W-1:0] data_mem [`DC_SETS];
    logic [`DC_SETS-1:0]   valid_q;
    logic [`DC_SETS-1:0]   dirty_q;

    // asynchronous read of the addressed set
    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_q[index_i];
    assign tag_o   = tag_mem[index_i];
    assign rdata_o = data_mem[index_i];

    assign hit_o = valid_o && (tag_o == tag_i);

    // data bytes under the mask, a fill brings a full mask
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < `DC_MASK_W; b++) begin
                if (wmask_i[b]) begin
                    data_mem[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
        if (fill_i) begin
            tag_mem[index_i] <= tag_i;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_i) begin
                valid_q[index_i] <= 1'b1;
            end
            // store data marks the line, a plain fill leaves it clean
            if (wr_en_i && set_dirty_i) begin
                dirty_q[index_i] <= 1'b1;
            end else if (fill_i) begin
                dirty_q[index_i] <= 1'b0;
            end
        end
    end

endmodule

// ==== dcache_ctrl.sv ====
/*
 dcache controller
 one FSM for loads and stores: lookup, write-back of a dirty
 victim, line fill from memory, per-set LRU bit, core done pulse
*/
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rd_i,
    input  logic                  wr_i,
    input  dcache_addr_t          addr_i,
    input  logic [`DC_DATA_W-1:0] wdata_i,
    input  logic [`DC_MASK_W-1:0] wmask_i,
    output logic [`DC_DATA_W-1:0] rdata_o,
    output logic                  done_o,
    input  logic                  mem_ok_i,
    input  logic [`DC_DATA_W-1:0] mem_rdata_i,
    output logic                  mem_rd_o,
    output logic                  mem_wr_o,
    output logic [`DC_ADDR_W-1:0] mem_addr_o,
    output logic [`DC_DATA_W-1:0] mem_wdata_o,
    input  logic                  hit0_i,
    input  logic                  hit1_i,
    input  logic                  valid0_i,
    input  logic                  valid1_i,
    input  logic                  dirty0_i,
    input  logic                  dirty1_i,
    input  logic [`DC_TAG_W-1:0]  tag0_i,
    input  logic [`DC_TAG_W-1:0]  tag1_i,
    input  logic [`DC_DATA_W-1:0] rdata0_i,
    input  logic [`DC_DATA_W-1:0] rdata1_i,
    output logic                  wr_en0_o,
    output logic                  wr_en1_o,
    output logic                  fill0_o,
    output logic                  fill1_o,
    output logic [`DC_MASK_W-1:0] wmask_o,
    output logic [`DC_DATA_W-1:0] wdata_o,
    output logic                  set_dirty_o
);

    dc_state_t             state_q;
    dc_state_t             state_d;
    logic [`DC_SETS-1:0]   lru_q;
    logic [`DC_DATA_W-1:0] rdata_q;
    logic [`DC_IDX_W-1:0]  idx;
    logic                  hit;
    logic                  hit_way;
    logic                  victim;
    logic                  victim_dirty;
    logic [`DC_TAG_W-1:0]  victim_tag;
    logic [`DC_DATA_W-1:0] fill_data;
    logic                  touch;
    logic                  touch_way;
    dcache_addr_t          wb_addr;
    dcache_addr_t          fill_addr;

    function automatic logic [`DC_DATA_W-1:0] merge_bytes(
        input logic [`DC_DATA_W-1:0] base,
        input logic [`DC_DATA_W-1:0] upd,
        input logic [`DC_MASK_W-1:0] mask
    );
        logic [`DC_DATA_W-1:0] res;
        res = base;
        for (int b = 0; b < `DC_MASK_W; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = upd[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign idx     = addr_i.f.index;
    assign hit     = hit0_i | hit1_i;
    assign hit_way = ~hit0_i;

    // invalid way first, way 0 before way 1, then the LRU way
    assign victim       = !valid0_i ? 1'b0 : (!valid1_i ? 1'b1 : lru_q[idx]);
    assign victim_dirty = victim ? (valid1_i & dirty1_i) : (valid0_i & dirty0_i);
    assign victim_tag   = victim ? tag1_i : tag0_i;

    // memory word with the store bytes laid over it
    assign fill_data = wr_i ? merge_bytes(mem_rdata_i, wdata_i, wmask_i) : mem_rdata_i;

    always_comb begin
        wb_addr          = addr_i;
        wb_addr.f.tag    = victim_tag;
        wb_addr.f.offset = '0;
        fill_addr          = addr_i;
        fill_addr.f.offset = '0;
    end

    // strobes are plain levels decoded from the state
    assign mem_rd_o    = (state_q == FILL);
    assign mem_wr_o    = (state_q == WBACK);
    assign mem_addr_o  = mem_wr_o ? wb_addr.word : fill_addr.word;
    assign mem_wdata_o = victim ? rdata1_i : rdata0_i;
    assign done_o      = (state_q == DONE);
    assign rdata_o     = rdata_q;

    always_comb begin
        state_d     = state_q;
        wr_en0_o    = 1'b0;
        wr_en1_o    = 1'b0;
        fill0_o     = 1'b0;
        fill1_o     = 1'b0;
        wmask_o     = wmask_i;
        wdata_o     = wdata_i;
        set_dirty_o = wr_i;
        touch       = 1'b0;
        touch_way   = hit_way;
        case (state_q)
            IDLE: begin
                if (rd_i || wr_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    touch    = 1'b1;
                    wr_en0_o = wr_i & ~hit_way;
                    wr_en1_o = wr_i & hit_way;
                    state_d  = DONE;
                end else if (victim_dirty) begin
                    state_d = WBACK;
                end else begin
                    state_d = FILL;
                end
            end
            WBACK: begin
                if (mem_ok_i) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                if (mem_ok_i) begin
                    touch     = 1'b1;
                    touch_way = victim;
                    wr_en0_o  = ~victim;
                    fill0_o   = ~victim;
                    wr_en1_o  = victim;
                    fill1_o   = victim;
                    wmask_o   = '1;
                    wdata_o   = fill_data;
                    state_d   = DONE;
                end
            end
            DONE: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
            lru_q   <= '0;
        end else begin
            state_q <= state_d;
            // lru names the way to evict next
            if (touch) begin
                lru_q[idx] <= ~touch_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == LOOKUP && hit) begin
            rdata_q <= hit_way ? rdata1_i : rdata0_i;
        end else if (state_q == FILL && mem_ok_i) begin
            rdata_q <= fill_data;
        end
    end

endmodule

// ==== dcache_top.sv ====
/*
 dcache top
 two-way set associative write-back data cache between a core
 and a slow memory; two ways side by side and one controller
*/
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rd_i,
    input  logic                  wr_i,
    input  logic [`DC_ADDR_W-1:0] addr_i,
    input  logic [`DC_DATA_W-1:0] wdata_i,
    input  logic [`DC_MASK_W-1:0] wmask_i,
    output logic [`DC_DATA_W-1:0] rdata_o,
    output logic                  done_o,
    output logic                  mem_rd_o,
    output logic                  mem_wr_o,
    output logic [`DC_ADDR_W-1:0] mem_addr_o,
    output logic [`DC_DATA_W-1:0] mem_wdata_o,
    input  logic                  mem_ok_i,
    input  logic [`DC_DATA_W-1:0] mem_rdata_i
);

    dcache_addr_t          req_addr;
    logic                  hit0, hit1;
    logic                  valid0, valid1;
    logic                  dirty0, dirty1;
    logic [`DC_TAG_W-1:0]  tag0, tag1;
    logic [`DC_DATA_W-1:0] rdata0, rdata1;
    logic                  wr_en0, wr_en1;
    logic                  fill0, fill1;
    logic [`DC_MASK_W-1:0] way_wmask;
    logic [`DC_DATA_W-1:0] way_wdata;
    logic                  set_dirty;

    assign req_addr = addr_i;

    dcache_way u_way0 (
        .clk(clk), .rst(rst),
        .index_i(req_addr.f.index), .tag_i(req_addr.f.tag),
        .wr_en_i(wr_en0), .wmask_i(way_wmask), .wdata_i(way_wdata),
        .fill_i(fill0), .set_dirty_i(set_dirty),
        .hit_o(hit0), .valid_o(valid0), .dirty_o(dirty0),
        .tag_o(tag0), .rdata_o(rdata0)
    );

    dcache_way u_way1 (
        .clk(clk), .rst(rst),
        .index_i(req_addr.f.index), .tag_i(req_addr.f.tag),
        .wr_en_i(wr_en1), .wmask_i(way_wmask), .wdata_i(way_wdata),
        .fill_i(fill1), .set_dirty_i(set_dirty),
        .hit_o(hit1), .valid_o(valid1), .dirty_o(dirty1),
        .tag_o(tag1), .rdata_o(rdata1)
    );

    dcache_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .rd_i(rd_i), .wr_i(wr_i), .addr_i(req_addr),
        .wdata_i(wdata_i), .wmask_i(wmask_i),
        .rdata_o(rdata_o), .done_o(done_o),
        .mem_ok_i(mem_ok_i), .mem_rdata_i(mem_rdata_i),
        .mem_rd_o(mem_rd_o), .mem_wr_o(mem_wr_o),
        .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o),
        .hit0_i(hit0), .hit1_i(hit1),
        .valid0_i(valid0), .valid1_i(valid1),
        .dirty0_i(dirty0), .dirty1_i(dirty1),
        .tag0_i(tag0), .tag1_i(tag1),
        .rdata0_i(rdata0), .rdata1_i(rdata1),
        .wr_en0_o(wr_en0), .wr_en1_o(wr_en1),
        .fill0_o(fill0), .fill1_o(fill1),
        .wmask_o(way_wmask), .wdata_o(way_wdata),
        .set_dirty_o(set_dirty)
    );

endmodule

// ==== dcache_properties.sv ====
/*
 dcache properties
 protocol assertions on the memory strobes and the done pulse
*/
`timescale 1ns/1ps

module dcache_properties (
    input logic        clk,
    input logic        rst,
    input logic        done_i,
    input logic        mem_rd_i,
    input logic        mem_wr_i,
    input logic        mem_ok_i,
    input logic [63:0] mem_addr_i
);

    int fail_count = 0;

    a_strobe_excl: assert property (@(posedge clk) disable iff (!rst)
        !(mem_rd_i && mem_wr_i))
        else begin
            $error("memory read and write strobes high together");
            fail_count++;
        end

    // address held while the memory has not answered
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst)
        (mem_rd_i || mem_wr_i) && !mem_ok_i |=> $stable(mem_addr_i))
        else begin
            $error("memory address changed while a strobe was waiting");
            fail_count++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        done_i |=> !done_i)
        else begin
            $error("done pulse lasted more than one cycle");
            fail_count++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        !rst |-> !(done_i || mem_rd_i || mem_wr_i))
        else begin
            $error("strobe high while reset is asserted");
            fail_count++;
        end

endmodule

bind dcache_top dcache_properties u_props (
    .clk(clk), .rst(rst),
    .done_i(done_o), .mem_rd_i(mem_rd_o), .mem_wr_i(mem_wr_o),
    .mem_ok_i(mem_ok_i), .mem_addr_i(mem_addr_o)
);

// ==== tb_dcache_checker.sv ====
/*
 dcache checker
 flat reference memory plus a two-way tag, dirty and LRU model;
 compares load data, write-back traffic and hit latency
*/
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tb_dcache_checker #(
    parameter logic [63:0] FILL_KEY = 64'h0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rd_i,
    input  logic                  wr_i,
    input  logic [`DC_ADDR_W-1:0] addr_i,
    input  logic [`DC_DATA_W-1:0] wdata_i,
    input  logic [`DC_MASK_W-1:0] wmask_i,
    input  logic [`DC_DATA_W-1:0] rdata_i,
    input  logic                  done_i,
    input  logic                  mem_rd_i,
    input  logic                  mem_wr_i,
    input  logic                  mem_ok_i,
    input  logic [`DC_ADDR_W-1:0] mem_addr_i,
    input  logic [`DC_DATA_W-1:0] mem_wdata_i,
    output int                    data_errs_o,
    output int                    proto_errs_o,
    output int                    checks_o
);

    logic [63:0]          ref_mem [logic [60:0]];
    logic [`DC_TAG_W-1:0] m_tag   [2][`DC_SETS];
    logic                 m_valid [2][`DC_SETS];
    logic                 m_dirty [2][`DC_SETS];
    logic                 m_lru   [`DC_SETS];

    logic        busy;
    int          cyc;
    logic        traffic;
    logic        fill_seen;
    logic        wb_seen;
    logic        p_wb;
    logic        p_hit;
    logic        p_way;
    logic [63:0] p_load;
    logic [63:0] p_wb_addr;
    logic [63:0] p_wb_data;
    logic [5:0]  cur_idx;

    initial begin
        data_errs_o  = 0;
        proto_errs_o = 0;
        checks_o     = 0;
        busy         = 1'b0;
    end

    function automatic logic [63:0] ref_read(input logic [63:0] a);
        if (ref_mem.exists(a[63:3])) begin
            return ref_mem[a[63:3]];
        end
        return {3'b000, a[63:3]} ^ FILL_KEY;
    endfunction

    function automatic logic [63:0] apply_mask(input logic [63:0] old_w,
                                               input logic [63:0] new_w,
                                               input logic [7:0] m);
        logic [63:0] keep;
        for (int b = 0; b < 8; b++) begin
            keep[8*b +: 8] = {8{m[b]}};
        end
        return (old_w & ~keep) | (new_w & keep);
    endfunction

    // expected outcome of an access; returns 1 when a write-back is due
    function automatic logic predict(input logic [63:0] a, output logic hit,
                                     output logic way, output logic [63:0] load_data,
                                     output logic [63:0] wb_addr, output logic [63:0] wb_data);
        logic [5:0] idx;
        idx = a[8:3];
        hit = 1'b1;
        if (m_valid[0][idx] && m_tag[0][idx] == a[63:9]) begin
            way = 1'b0;
        end else if (m_valid[1][idx] && m_tag[1][idx] == a[63:9]) begin
            way = 1'b1;
        end else begin
            hit = 1'b0;
            way = !m_valid[0][idx] ? 1'b0 : (!m_valid[1][idx] ? 1'b1 : m_lru[idx]);
        end
        load_data = ref_read(a);
        wb_addr   = {m_tag[way][idx], idx, 3'b000};
        wb_data   = ref_read(wb_addr);
        return !hit && m_valid[way][idx] && m_dirty[way][idx];
    endfunction

    always @(negedge clk) begin
        if (!rst) begin
            for (int k = 0; k < `DC_SETS; k++) begin
                m_valid[0][k] = 1'b0;
                m_valid[1][k] = 1'b0;
                m_dirty[0][k] = 1'b0;
                m_dirty[1][k] = 1'b0;
                m_lru[k]      = 1'b0;
            end
            busy = 1'b0;
            if (done_i || mem_rd_i || mem_wr_i) begin
                $display("ERR %0t: strobe high during reset", $time);
                proto_errs_o++;
            end
        end else begin
            if (busy) begin
                cyc++;
            end else if (rd_i || wr_i) begin
                busy      = 1'b1;
                cyc       = 1;
                traffic   = 1'b0;
                fill_seen = 1'b0;
                wb_seen   = 1'b0;
            end
            if (mem_rd_i || mem_wr_i) begin
                traffic = 1'b1;
            end
            if (mem_wr_i && mem_ok_i) begin
                wb_seen = 1'b1;
                p_wb = predict(addr_i, p_hit, p_way, p_load, p_wb_addr, p_wb_data);
                if (!p_wb) begin
                    $display("ERR %0t: write-back to %h not expected", $time, mem_addr_i);
                    proto_errs_o++;
                end else if (mem_addr_i !== p_wb_addr || mem_wdata_i !== p_wb_data) begin
                    $display("ERR %0t: write-back %h:%h, expected %h:%h", $time,
                             mem_addr_i, mem_wdata_i, p_wb_addr, p_wb_data);
                    data_errs_o++;
                end
            end
            if (mem_rd_i && mem_ok_i) begin
                fill_seen = 1'b1;
                if (mem_addr_i !== {addr_i[63:3], 3'b000}) begin
                    $display("ERR %0t: fill address %h for request %h", $time,
                             mem_addr_i, addr_i);
                    data_errs_o++;
                end
            end
            if (done_i) begin
                checks_o++;
                p_wb = predict(addr_i, p_hit, p_way, p_load, p_wb_addr, p_wb_data);
                if (!busy) begin
                    $display("ERR %0t: done_o without a pending request", $time);
                    proto_errs_o++;
                end
                if (p_wb && !wb_seen) begin
                    $display("ERR %0t: dirty victim %h never written back", $time, p_wb_addr);
                    proto_errs_o++;
                end
                if (p_hit && (cyc != 3 || traffic)) begin
                    $display("ERR %0t: hit on %h took %0d cycles, memory traffic %0b",
                             $time, addr_i, cyc, traffic);
                    proto_errs_o++;
                end else if (!p_hit && !fill_seen) begin
                    $display("ERR %0t: miss on %h finished without a fill", $time, addr_i);
                    proto_errs_o++;
                end
                if (rd_i && rdata_i !== p_load) begin
                    $display("ERR %0t: load %h returned %h, expected %h", $time,
                             addr_i, rdata_i, p_load);
                    data_errs_o++;
                end
                // model follows the access
                cur_idx = addr_i[8:3];
                if (!p_hit) begin
                    m_tag[p_way][cur_idx]   = addr_i[63:9];
                    m_valid[p_way][cur_idx] = 1'b1;
                    m_dirty[p_way][cur_idx] = 1'b0;
                end
                if (wr_i) begin
                    m_dirty[p_way][cur_idx] = 1'b1;
                    ref_mem[addr_i[63:3]] = apply_mask(ref_read(addr_i), wdata_i, wmask_i);
                end
                m_lru[cur_idx] = ~p_way;
                busy = 1'b0;
            end
        end
    end

endmodule

// ==== tb_dcache.sv ====
/*
 dcache testbench top
 clock, reset, core-side stimulus and a behavioral backing memory
 with random latency; the checker module does the comparing
*/
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tb_dcache;

    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 400;
    localparam int N_DIRECTED   = 16;
    // worst case miss with write-back and slow memory
    localparam int OP_CYCLES    = 15;
    localparam int MAX_CYCLES   = RESET_CYCLES + (N_RANDOM + N_DIRECTED) * OP_CYCLES * 5 / 4;
    localparam logic [63:0] FILL_KEY = 64'h5a5a_c3c3_0f0f_9669;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  rd;
    logic                  wr;
    logic [`DC_ADDR_W-1:0] addr;
    logic [`DC_DATA_W-1:0] wdata;
    logic [`DC_MASK_W-1:0] wmask;
    logic [`DC_DATA_W-1:0] rdata;
    logic                  done;
    logic                  mem_rd;
    logic                  mem_wr;
    logic [`DC_ADDR_W-1:0] mem_addr;
    logic [`DC_DATA_W-1:0] mem_wdata;
    logic                  mem_ok;
    logic [`DC_DATA_W-1:0] mem_rdata;

    logic [63:0] backing [logic [60:0]];
    int          wait_cycles;
    int          cycle_cnt = 0;
    int          data_errs;
    int          proto_errs;
    int          checks;
    int          assert_errs;
    logic        op_wr;
    logic [63:0] op_addr;
    logic [63:0] op_data;
    logic [7:0]  op_mask;

    always #20 clk = ~clk;

    dcache_top u_dcache_top (
        .clk(clk), .rst(rst),
        .rd_i(rd), .wr_i(wr), .addr_i(addr), .wdata_i(wdata), .wmask_i(wmask),
        .rdata_o(rdata), .done_o(done),
        .mem_rd_o(mem_rd), .mem_wr_o(mem_wr),
        .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
        .mem_ok_i(mem_ok), .mem_rdata_i(mem_rdata)
    );

    tb_dcache_checker #(.FILL_KEY(FILL_KEY)) u_checker (
        .clk(clk), .rst(rst),
        .rd_i(rd), .wr_i(wr), .addr_i(addr), .wdata_i(wdata), .wmask_i(wmask),
        .rdata_i(rdata), .done_i(done),
        .mem_rd_i(mem_rd), .mem_wr_i(mem_wr), .mem_ok_i(mem_ok),
        .mem_addr_i(mem_addr), .mem_wdata_i(mem_wdata),
        .data_errs_o(data_errs), .proto_errs_o(proto_errs), .checks_o(checks)
    );

    assign assert_errs = u_dcache_top.u_props.fail_count;

    function automatic logic [63:0] backing_read(input logic [63:0] a);
        if (backing.exists(a[63:3])) begin
            return backing[a[63:3]];
        end
        return {3'b000, a[63:3]} ^ FILL_KEY;
    endfunction

    // few tags on three neighbouring sets, so evictions are frequent
    function automatic logic [63:0] pick_addr();
        logic [54:0] tag;
        logic [5:0]  idx;
        logic [2:0]  off;
        tag = 55'($urandom_range(5, 0)) * 55'h0_0400_0101;
        idx = 6'($urandom_range(2, 0)) + 6'd60;
        off = 3'($urandom_range(7, 0));
        return {tag, idx, off};
    endfunction

    task automatic access(input logic is_wr, input logic [63:0] a,
                          input logic [63:0] d, input logic [7:0] m);
        rd    = !is_wr;
        wr    = is_wr;
        addr  = a;
        wdata = d;
        wmask = m;
        do begin
            @(negedge clk);
        end while (!done);
        @(posedge clk);
        #2;
        rd = 1'b0;
        wr = 1'b0;
    endtask

    task automatic finish_run();
        $display("errors: data %0d, protocol %0d, assertion %0d; %0d accesses checked",
                 data_errs, proto_errs, assert_errs, checks);
        if (data_errs + proto_errs + assert_errs == 0 && checks > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // memory answers a held strobe after 1 to 4 cycles
    initial begin
        mem_ok    = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #2;
            if (rst && (mem_rd || mem_wr)) begin
                wait_cycles = $urandom_range(3, 0);
                repeat (wait_cycles) begin
                    @(posedge clk);
                    #2;
                end
                if (mem_wr) begin
                    backing[mem_addr[63:3]] = mem_wdata;
                end else begin
                    mem_rdata = backing_read(mem_addr);
                end
                mem_ok = 1'b1;
                @(posedge clk);
                #2;
                mem_ok = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("timeout: run did not complete within %0d cycles", MAX_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(52));
        rst   = 1'b0;
        rd    = 1'b0;
        wr    = 1'b0;
        addr  = '0;
        wdata = '0;
        wmask = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b1;
        @(posedge clk);
        #2;
        // cold load, then a hit on the same word
        access(1'b0, 64'h0000_0000_0001_2340, '0, '0);
        access(1'b0, 64'h0000_0000_0001_2340, '0, '0);
        // partial store hit and read back
        access(1'b1, 64'h0000_0000_0001_2340, 64'hdead_beef_0123_4567, 8'b0011_0110);
        access(1'b0, 64'h0000_0000_0001_2340, '0, '0);
        // three tags on set 5, dirty victim first, then a clean one
        access(1'b1, 64'h0000_0000_0000_2028, 64'h1111_2222_3333_4444, 8'hff);
        access(1'b0, 64'h0000_0000_0000_4028, '0, '0);
        access(1'b0, 64'h8000_0000_0000_6028, '0, '0);
        access(1'b0, 64'h0000_0000_0000_2028, '0, '0);
        for (int i = 0; i < N_RANDOM; i++) begin
            op_wr   = 1'($urandom_range(1, 0));
            op_addr = pick_addr();
            op_data = {$urandom(), $urandom()};
            op_mask = ($urandom_range(3, 0) == 0) ? 8'hff : 8'($urandom_range(255, 1));
            access(op_wr, op_addr, op_data, op_mask);
        end
        finish_run();
    end

endmodule

// ==== project.f ====
+incdir+.
dcache_pkg.sv
dcache_way.sv
dcache_ctrl.sv
dcache_top.sv
dcache_properties.sv
tb_dcache_checker.sv
tb_dcache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dcache
LOG       ?= sim.log
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUNFLAGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation into $(LOG), check the log"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1; rc=$$?; \
	cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "sim failed" $(LOG); then \
		echo "test FAILED, see $(LOG)"; exit 1; \
	fi
	@echo "test PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
